// ==== verilog/tex_dcr_pkg.sv ====
`default_nettype none

package tex_dcr_pkg;

    localparam int DCR_ADDR_BITS = 8;
    localparam int DCR_DATA_BITS = 32;

    typedef logic [DCR_ADDR_BITS-1:0] dcr_addr_t;
    typedef logic [DCR_DATA_BITS-1:0] dcr_data_t;

    // Wrap and log-dimension writes carry one field per axis, u in the low half.
    typedef struct packed {
        logic [DCR_DATA_BITS/2-1:0] hi;
        logic [DCR_DATA_BITS/2-1:0] lo;
    } dcr_halves_t;

    typedef union packed {
        dcr_data_t   full;
        dcr_halves_t halves;
    } dcr_word_u;

    // Address map of the texture configuration space.
    localparam dcr_addr_t DCR_TEX_STAGE       = 8'h01; // Selects the stage for later writes.
    localparam dcr_addr_t DCR_TEX_ADDR        = 8'h02;
    localparam dcr_addr_t DCR_TEX_FORMAT      = 8'h03;
    localparam dcr_addr_t DCR_TEX_WRAP        = 8'h04;
    localparam dcr_addr_t DCR_TEX_LOGDIM      = 8'h05;

    // Mip offset of level j lives at this base plus j.
    localparam dcr_addr_t DCR_TEX_MIPOFF_BASE = 8'h08;

    localparam int TEX_LOD_MAX     = 7;
    localparam int TEX_MIPOFF_BITS = 24;

endpackage

`default_nettype wire

// ==== verilog/tex_types_pkg.sv ====
`default_nettype none

package tex_types_pkg;

    typedef logic [31:0] tex_addr_t;

    typedef logic signed [15:0] tex_coord_t;

    typedef logic [$clog2(tex_dcr_pkg::TEX_LOD_MAX+1)-1:0] tex_lod_t;

    // Log2 of a texture dimension, never above 12.
    typedef logic [3:0] tex_logdim_t;

    typedef logic [tex_dcr_pkg::TEX_MIPOFF_BITS-1:0] tex_mipoff_t;

    // The code is the log2 of the texel size in bytes.
    typedef enum logic [1:0] {
        FMT_R8       = 2'd0,
        FMT_R5G6B5   = 2'd1,
        FMT_R8G8B8A8 = 2'd2
    } tex_format_e;

    typedef enum logic [1:0] {
        WRAP_CLAMP  = 2'd0,
        WRAP_REPEAT = 2'd1,
        WRAP_MIRROR = 2'd2
    } tex_wrap_e;

    // Code 3 has no format of its own and is sized like a 4-byte texel.
    function automatic logic [1:0] fmt_bytelog(tex_format_e fmt);
        logic [1:0] code;
        code = fmt;
        return code[1] ? 2'd2 : code;
    endfunction

endpackage

`default_nettype wire

// ==== verilog/tex_wrap.sv ====
`timescale 1ns/1ps
`default_nettype none

module tex_wrap (
    input  wire tex_types_pkg::tex_coord_t  coord,
    input  wire tex_types_pkg::tex_logdim_t logsize,
    input  wire tex_types_pkg::tex_wrap_e   mode,
    output tex_types_pkg::tex_coord_t       wrapped
);

    logic [15:0] raw;
    logic [15:0] size;
    logic [15:0] mask;      // size - 1
    logic [15:0] mask2;     // 2*size - 1, the mirror period minus one.
    logic [15:0] mirror_pos;
    logic [15:0] result;

    assign raw   = coord;
    assign size  = 16'd1 << logsize;
    assign mask  = size - 16'd1;
    assign mask2 = {mask[14:0], 1'b1};

    assign mirror_pos = raw & mask2;

    always_comb begin
        case (mode)
            tex_types_pkg::WRAP_REPEAT: begin
                result = raw & mask; // Two's complement keeps -1 at size-1.
            end
            tex_types_pkg::WRAP_MIRROR: begin
                if ((mirror_pos & size) != 16'd0) begin
                    result = mask2 - mirror_pos; // Second half of the period runs backwards.
                end else begin
                    result = mirror_pos;
                end
            end
            default: begin
                // Clamp, also taken by the unused code 3.
                if (raw[15]) begin
                    result = 16'd0;
                end else if ((raw & ~mask) != 16'd0) begin
                    result = mask;
                end else begin
                    result = raw;
                end
            end
        endcase
    end

    assign wrapped = tex_types_pkg::tex_coord_t'(result);

endmodule

`default_nettype wire

// ==== verilog/tex_dcr.sv ====
`timescale 1ns/1ps
`default_nettype none

module tex_dcr #(
    parameter int NUM_STAGES = 4
) (
    input  wire                          clk,
    input  wire                          reset,

    input  wire                          dcr_wr_valid,
    input  wire tex_dcr_pkg::dcr_addr_t  dcr_wr_addr,
    input  wire tex_dcr_pkg::dcr_data_t  dcr_wr_data,

    output tex_types_pkg::tex_addr_t     cfg_baddr    [NUM_STAGES],
    output tex_types_pkg::tex_format_e   cfg_format   [NUM_STAGES],
    output tex_types_pkg::tex_wrap_e     cfg_wrap_u   [NUM_STAGES],
    output tex_types_pkg::tex_wrap_e     cfg_wrap_v   [NUM_STAGES],
    output tex_types_pkg::tex_logdim_t   cfg_logdim_u [NUM_STAGES],
    output tex_types_pkg::tex_logdim_t   cfg_logdim_v [NUM_STAGES],
    output tex_types_pkg::tex_mipoff_t   cfg_mipoff   [NUM_STAGES][tex_dcr_pkg::TEX_LOD_MAX+1]
);

    localparam int STAGE_BITS = $clog2(NUM_STAGES);
    localparam int LOD_BITS   = $bits(tex_types_pkg::tex_lod_t);

    logic [STAGE_BITS-1:0]   stage;     // Bank that receives configuration writes.
    tex_dcr_pkg::dcr_word_u  word;
    tex_dcr_pkg::dcr_addr_t  mip_index;

    assign word = dcr_wr_data;

    // Addresses below the mip base wrap around to large values and fail the range check.
    assign mip_index = dcr_wr_addr - tex_dcr_pkg::DCR_TEX_MIPOFF_BASE;

    always_ff @(posedge clk) begin
        if (reset) begin
            stage <= '0;
            for (int i = 0; i < NUM_STAGES; i++) begin
                cfg_baddr[i]    <= '0;
                cfg_format[i]   <= tex_types_pkg::FMT_R8;
                cfg_wrap_u[i]   <= tex_types_pkg::WRAP_CLAMP;
                cfg_wrap_v[i]   <= tex_types_pkg::WRAP_CLAMP;
                cfg_logdim_u[i] <= '0;
                cfg_logdim_v[i] <= '0;
                for (int j = 0; j <= tex_dcr_pkg::TEX_LOD_MAX; j++) begin
                    cfg_mipoff[i][j] <= '0;
                end
            end
        end else if (dcr_wr_valid) begin
            case (dcr_wr_addr)
                tex_dcr_pkg::DCR_TEX_STAGE: begin
                    stage <= word.full[STAGE_BITS-1:0]; // Upper bits are don't care.
                end
                tex_dcr_pkg::DCR_TEX_ADDR: begin
                    cfg_baddr[stage] <= word.full;
                end
                tex_dcr_pkg::DCR_TEX_FORMAT: begin
                    cfg_format[stage] <= tex_types_pkg::tex_format_e'(word.full[1:0]);
                end
                tex_dcr_pkg::DCR_TEX_WRAP: begin
                    cfg_wrap_u[stage] <= tex_types_pkg::tex_wrap_e'(word.halves.lo[1:0]);
                    cfg_wrap_v[stage] <= tex_types_pkg::tex_wrap_e'(word.halves.hi[1:0]);
                end
                tex_dcr_pkg::DCR_TEX_LOGDIM: begin
                    cfg_logdim_u[stage] <= word.halves.lo[3:0];
                    cfg_logdim_v[stage] <= word.halves.hi[3:0];
                end
                default: begin
                    // Anything outside the mip table is an unmapped address.
                    if (mip_index <= tex_dcr_pkg::TEX_LOD_MAX) begin
                        cfg_mipoff[stage][mip_index[LOD_BITS-1:0]] <=
                            word.full[tex_dcr_pkg::TEX_MIPOFF_BITS-1:0];
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/tex_addr.sv ====
`timescale 1ns/1ps
`default_nettype none

module tex_addr #(
    parameter int NUM_STAGES = 4
) (
    input  wire                               clk,
    input  wire                               reset,

    input  wire tex_types_pkg::tex_addr_t     cfg_baddr    [NUM_STAGES],
    input  wire tex_types_pkg::tex_format_e   cfg_format   [NUM_STAGES],
    input  wire tex_types_pkg::tex_wrap_e     cfg_wrap_u   [NUM_STAGES],
    input  wire tex_types_pkg::tex_wrap_e     cfg_wrap_v   [NUM_STAGES],
    input  wire tex_types_pkg::tex_logdim_t   cfg_logdim_u [NUM_STAGES],
    input  wire tex_types_pkg::tex_logdim_t   cfg_logdim_v [NUM_STAGES],
    input  wire tex_types_pkg::tex_mipoff_t
                               cfg_mipoff [NUM_STAGES][tex_dcr_pkg::TEX_LOD_MAX+1],

    input  wire                               req_valid,
    output logic                              req_ready,
    input  wire [$clog2(NUM_STAGES)-1:0]      req_stage,
    input  wire tex_types_pkg::tex_lod_t      req_lod,
    input  wire tex_types_pkg::tex_coord_t    req_u,
    input  wire tex_types_pkg::tex_coord_t    req_v,

    output logic                              rsp_valid,
    input  wire                               rsp_ready,
    output tex_types_pkg::tex_addr_t          rsp_addr
);

    logic req_fire;
    logic s2_ready;

    // Stage one inputs, taken from the addressed bank.
    tex_types_pkg::tex_logdim_t sel_logu;
    tex_types_pkg::tex_logdim_t sel_logv;
    tex_types_pkg::tex_logdim_t lvl_logu;
    tex_types_pkg::tex_logdim_t lvl_logv;
    tex_types_pkg::tex_logdim_t lod_ext;
    tex_types_pkg::tex_addr_t   sel_base;
    tex_types_pkg::tex_coord_t  wrap_u;
    tex_types_pkg::tex_coord_t  wrap_v;

    logic                       s1_valid;
    tex_types_pkg::tex_coord_t  s1_u;
    tex_types_pkg::tex_coord_t  s1_v;
    tex_types_pkg::tex_logdim_t s1_logu;
    tex_types_pkg::tex_addr_t   s1_base;
    tex_types_pkg::tex_format_e s1_format;

    tex_types_pkg::tex_addr_t   texel_idx;
    tex_types_pkg::tex_addr_t   s2_addr_next;

    // A slot may load when it is empty or its content leaves this cycle.
    assign s2_ready  = !rsp_valid || rsp_ready;
    assign req_ready = !s1_valid || s2_ready;
    assign req_fire  = req_valid && req_ready;

    assign lod_ext = tex_types_pkg::tex_logdim_t'(req_lod);

    always_comb begin
        sel_logu = cfg_logdim_u[req_stage];
        sel_logv = cfg_logdim_v[req_stage];
        // Levels past the smallest mip collapse to a single texel.
        lvl_logu = (sel_logu > lod_ext) ? sel_logu - lod_ext : '0;
        lvl_logv = (sel_logv > lod_ext) ? sel_logv - lod_ext : '0;
        sel_base = cfg_baddr[req_stage] +
                   tex_types_pkg::tex_addr_t'(cfg_mipoff[req_stage][req_lod]);
    end

    tex_wrap wrap_u_i (
        .coord   (req_u),
        .logsize (lvl_logu),
        .mode    (cfg_wrap_u[req_stage]),
        .wrapped (wrap_u)
    );

    tex_wrap wrap_v_i (
        .coord   (req_v),
        .logsize (lvl_logv),
        .mode    (cfg_wrap_v[req_stage]),
        .wrapped (wrap_v)
    );

    // Wrapped coordinates are never negative, so zero extension is exact.
    assign texel_idx    = ({16'b0, s1_v} << s1_logu) + {16'b0, s1_u};
    assign s2_addr_next = s1_base + (texel_idx << tex_types_pkg::fmt_bytelog(s1_format));

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid  <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            if (req_ready) begin
                s1_valid <= req_valid;
            end
            if (s2_ready) begin
                rsp_valid <= s1_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            s1_u      <= wrap_u;
            s1_v      <= wrap_v;
            s1_logu   <= lvl_logu;
            s1_base   <= sel_base;
            s1_format <= cfg_format[req_stage];
        end
        if (s2_ready && s1_valid) begin
            rsp_addr <= s2_addr_next; // Held while the response waits.
        end
    end

endmodule

`default_nettype wire

// ==== verilog/tex_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module tex_unit #(
    parameter int NUM_STAGES = 4
) (
    input  wire                            clk,
    input  wire                            reset,

    input  wire                            dcr_wr_valid,
    input  wire tex_dcr_pkg::dcr_addr_t    dcr_wr_addr,
    input  wire tex_dcr_pkg::dcr_data_t    dcr_wr_data,

    input  wire                            req_valid,
    output wire                            req_ready,
    input  wire [$clog2(NUM_STAGES)-1:0]   req_stage,
    input  wire tex_types_pkg::tex_lod_t   req_lod,
    input  wire tex_types_pkg::tex_coord_t req_u,
    input  wire tex_types_pkg::tex_coord_t req_v,

    output wire                            rsp_valid,
    input  wire                            rsp_ready,
    output tex_types_pkg::tex_addr_t       rsp_addr
);

    // Per-stage configuration, straight from the DCR registers.
    tex_types_pkg::tex_addr_t    cfg_baddr    [NUM_STAGES];
    tex_types_pkg::tex_format_e  cfg_format   [NUM_STAGES];
    tex_types_pkg::tex_wrap_e    cfg_wrap_u   [NUM_STAGES];
    tex_types_pkg::tex_wrap_e    cfg_wrap_v   [NUM_STAGES];
    tex_types_pkg::tex_logdim_t  cfg_logdim_u [NUM_STAGES];
    tex_types_pkg::tex_logdim_t  cfg_logdim_v [NUM_STAGES];
    tex_types_pkg::tex_mipoff_t  cfg_mipoff   [NUM_STAGES][tex_dcr_pkg::TEX_LOD_MAX+1];

    tex_dcr #(
        .NUM_STAGES (NUM_STAGES)
    ) dcr_i (
        .clk          (clk),
        .reset        (reset),
        .dcr_wr_valid (dcr_wr_valid),
        .dcr_wr_addr  (dcr_wr_addr),
        .dcr_wr_data  (dcr_wr_data),
        .cfg_baddr    (cfg_baddr),
        .cfg_format   (cfg_format),
        .cfg_wrap_u   (cfg_wrap_u),
        .cfg_wrap_v   (cfg_wrap_v),
        .cfg_logdim_u (cfg_logdim_u),
        .cfg_logdim_v (cfg_logdim_v),
        .cfg_mipoff   (cfg_mipoff)
    );

    tex_addr #(
        .NUM_STAGES (NUM_STAGES)
    ) addr_i (
        .clk          (clk),
        .reset        (reset),
        .cfg_baddr    (cfg_baddr),
        .cfg_format   (cfg_format),
        .cfg_wrap_u   (cfg_wrap_u),
        .cfg_wrap_v   (cfg_wrap_v),
        .cfg_logdim_u (cfg_logdim_u),
        .cfg_logdim_v (cfg_logdim_v),
        .cfg_mipoff   (cfg_mipoff),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .req_stage    (req_stage),
        .req_lod      (req_lod),
        .req_u        (req_u),
        .req_v        (req_v),
        .rsp_valid    (rsp_valid),
        .rsp_ready    (rsp_ready),
        .rsp_addr     (rsp_addr)
    );

endmodule

`default_nettype wire

// ==== dv/tex_ref.svh ====
`ifndef TEX_REF_SVH
`define TEX_REF_SVH

// Shadow of the stage banks, kept in step with every DCR write the testbench issues.
int                       sh_stage;
tex_types_pkg::tex_addr_t sh_baddr  [NUM_STAGES];
int                       sh_format [NUM_STAGES];
int                       sh_wrap_u [NUM_STAGES];
int                       sh_wrap_v [NUM_STAGES];
int                       sh_log_u  [NUM_STAGES];
int                       sh_log_v  [NUM_STAGES];
tex_types_pkg::tex_addr_t sh_mipoff [NUM_STAGES][tex_dcr_pkg::TEX_LOD_MAX+1];

task automatic shadow_reset();
    sh_stage = 0;
    for (int s = 0; s < NUM_STAGES; s++) begin
        sh_baddr[s]  = '0;
        sh_format[s] = 0;
        sh_wrap_u[s] = 0;
        sh_wrap_v[s] = 0;
        sh_log_u[s]  = 0;
        sh_log_v[s]  = 0;
        for (int j = 0; j <= tex_dcr_pkg::TEX_LOD_MAX; j++) begin
            sh_mipoff[s][j] = '0;
        end
    end
endtask

task automatic shadow_write(tex_dcr_pkg::dcr_addr_t addr, tex_dcr_pkg::dcr_data_t data);
    int lvl;
    lvl = int'(addr) - int'(tex_dcr_pkg::DCR_TEX_MIPOFF_BASE);
    if (addr == tex_dcr_pkg::DCR_TEX_STAGE) begin
        sh_stage = data % NUM_STAGES;
    end else if (addr == tex_dcr_pkg::DCR_TEX_ADDR) begin
        sh_baddr[sh_stage] = data;
    end else if (addr == tex_dcr_pkg::DCR_TEX_FORMAT) begin
        sh_format[sh_stage] = data & 3;
    end else if (addr == tex_dcr_pkg::DCR_TEX_WRAP) begin
        sh_wrap_u[sh_stage] = data & 3;
        sh_wrap_v[sh_stage] = (data >> 16) & 3;
    end else if (addr == tex_dcr_pkg::DCR_TEX_LOGDIM) begin
        sh_log_u[sh_stage] = data & 15;
        sh_log_v[sh_stage] = (data >> 16) & 15;
    end else if (lvl >= 0 && lvl <= tex_dcr_pkg::TEX_LOD_MAX) begin
        sh_mipoff[sh_stage][lvl] = data & 32'h00FF_FFFF;
    end
endtask

// Mode 1 repeats, mode 2 mirrors, anything else clamps.
function automatic int wrap_ref(int c, int logsize, int mode);
    int size;
    int m;
    size = 1 << logsize;
    case (mode)
        1: begin
            m = c % size;
            m = (m < 0) ? m + size : m;
        end
        2: begin
            m = c % (2 * size);
            m = (m < 0) ? m + 2 * size : m;
            m = (m >= size) ? 2 * size - 1 - m : m;
        end
        default: m = (c < 0) ? 0 : ((c >= size) ? size - 1 : c);
    endcase
    return m;
endfunction

function automatic tex_types_pkg::tex_addr_t ref_addr(int stage, int lod, int u, int v);
    int lvl_u;
    int lvl_v;
    int bytes;
    int texel;
    lvl_u = (sh_log_u[stage] > lod) ? sh_log_u[stage] - lod : 0;
    lvl_v = (sh_log_v[stage] > lod) ? sh_log_v[stage] - lod : 0;
    bytes = (sh_format[stage] == 0) ? 1 : ((sh_format[stage] == 1) ? 2 : 4);
    texel = wrap_ref(v, lvl_v, sh_wrap_v[stage]) * (1 << lvl_u) +
            wrap_ref(u, lvl_u, sh_wrap_u[stage]);
    return sh_baddr[stage] + sh_mipoff[stage][lod] + tex_types_pkg::tex_addr_t'(texel * bytes);
endfunction

`endif

// ==== dv/tex_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module tex_unit_tb;

    localparam int NUM_STAGES = 4;
    localparam int STAGE_BITS = $clog2(NUM_STAGES);
    localparam int NUM_RANDOM = 400;

    // About 600 lookups at up to 6 cycles each plus the writes, with a fivefold margin.
    localparam int LOOKUP_BUDGET     = 600;
    localparam int CYCLES_PER_LOOKUP = 6;
    localparam int WRITE_BUDGET      = 400;
    localparam int TIMEOUT_CYCLES    = 5 * (LOOKUP_BUDGET * CYCLES_PER_LOOKUP + WRITE_BUDGET);

    logic                           clk;
    logic                           reset;
    logic                           dcr_wr_valid;
    tex_dcr_pkg::dcr_addr_t         dcr_wr_addr;
    tex_dcr_pkg::dcr_data_t         dcr_wr_data;
    logic                           req_valid;
    wire                            req_ready;
    logic [STAGE_BITS-1:0]          req_stage;
    tex_types_pkg::tex_lod_t        req_lod;
    tex_types_pkg::tex_coord_t      req_u;
    tex_types_pkg::tex_coord_t      req_v;
    wire                            rsp_valid;
    logic                           rsp_ready;
    wire tex_types_pkg::tex_addr_t  rsp_addr;

    integer                         seed;
    integer                         ready_seed;
    int                             cycle = 0;
    logic                           random_ready;   // rsp_ready toggles while set.
    logic                           hold_pending;
    tex_types_pkg::tex_addr_t       held_addr;
    tex_types_pkg::tex_addr_t       exp_q [$];
    string                          name_q [$];

    `include "tex_ref.svh"

    tex_unit #(
        .NUM_STAGES (NUM_STAGES)
    ) dut_i (
        .clk          (clk),
        .reset        (reset),
        .dcr_wr_valid (dcr_wr_valid),
        .dcr_wr_addr  (dcr_wr_addr),
        .dcr_wr_data  (dcr_wr_data),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .req_stage    (req_stage),
        .req_lod      (req_lod),
        .req_u        (req_u),
        .req_v        (req_v),
        .rsp_valid    (rsp_valid),
        .rsp_ready    (rsp_ready),
        .rsp_addr     (rsp_addr)
    );

    always #4 clk = ~clk;

    task automatic report_failure(string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "Stopped at the first failure.");
    endtask

    task automatic check_addr(string name, tex_types_pkg::tex_addr_t exp,
                              tex_types_pkg::tex_addr_t act);
        if (act !== exp) begin
            report_failure($sformatf("** Error: %s expected 0x%08h actual 0x%08h",
                                     name, exp, act));
        end
    endtask

    task automatic dcr_write(tex_dcr_pkg::dcr_addr_t addr, tex_dcr_pkg::dcr_data_t data);
        dcr_wr_valid = 1'b1;
        dcr_wr_addr  = addr;
        dcr_wr_data  = data;
        @(posedge clk);
        #1;
        dcr_wr_valid = 1'b0;
        shadow_write(addr, data);
    endtask

    task automatic write_mipoff(int lvl, tex_dcr_pkg::dcr_data_t data);
        dcr_write(tex_dcr_pkg::dcr_addr_t'(tex_dcr_pkg::DCR_TEX_MIPOFF_BASE + lvl), data);
    endtask

    // The expected address is taken from the shadow as it stands at the accepting edge.
    task automatic lookup(string name, int stage, int lod, int u, int v);
        logic                      accepted;
        tex_types_pkg::tex_coord_t cu;
        tex_types_pkg::tex_coord_t cv;
        cu        = tex_types_pkg::tex_coord_t'(u);
        cv        = tex_types_pkg::tex_coord_t'(v);
        req_valid = 1'b1;
        req_stage = stage[STAGE_BITS-1:0];
        req_lod   = lod[2:0];
        req_u     = cu;
        req_v     = cv;
        accepted  = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = req_ready;
            @(posedge clk);
            #1;
        end
        exp_q.push_back(ref_addr(stage, lod, cu, cv));
        name_q.push_back(name);
        req_valid = 1'b0;
    endtask

    task automatic set_backpressure(logic on);
        @(negedge clk);
        random_ready = on;
        @(posedge clk);
        #1;
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    // Needs an empty pipeline and rsp_ready held high.
    task automatic check_latency(string name, int stage, int lod, int u, int v);
        lookup(name, stage, lod, u, v);
        @(negedge clk);
        if (rsp_valid) begin
            report_failure("Response appeared one cycle early after acceptance.");
        end else begin
            @(negedge clk);
            if (!rsp_valid) begin
                report_failure("Response did not appear two cycles after acceptance.");
            end
        end
        drain();
    endtask

    always @(posedge clk) begin
        #1;
        rsp_ready = random_ready ? (($random(ready_seed) & 1) != 0) : 1'b1;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            report_failure($sformatf("Timeout after %0d cycles, %0d responses outstanding.",
                                     cycle, exp_q.size()));
        end
    end

    always @(posedge clk) begin
        if (!reset) begin
            if (hold_pending) begin
                if (!rsp_valid) begin
                    report_failure("rsp_valid dropped while a response was waiting.");
                end else begin
                    check_addr("held response", held_addr, rsp_addr);
                end
            end
            if (rsp_valid && rsp_ready) begin
                if (exp_q.size() == 0) begin
                    report_failure($sformatf("Unexpected response with address 0x%08h.",
                                             rsp_addr));
                end else begin
                    check_addr(name_q.pop_front(), exp_q.pop_front(), rsp_addr);
                end
            end
            hold_pending = rsp_valid && !rsp_ready;
            held_addr    = rsp_addr;
        end
    end

    initial begin
        int                     s;
        int                     j;
        int                     m;
        int                     i;
        int                     u;
        int                     v;
        int                     order [4];
        int                     coords [10];
        tex_dcr_pkg::dcr_addr_t bad_addrs [5];
        tex_dcr_pkg::dcr_data_t rnd;

        seed         = 32'h4b5c;
        ready_seed   = seed ^ 32'h5a5a;
        clk          = 1'b0;
        reset        = 1'b1;
        dcr_wr_valid = 1'b0;
        dcr_wr_addr  = '0;
        dcr_wr_data  = '0;
        req_valid    = 1'b0;
        req_stage    = '0;
        req_lod      = '0;
        req_u        = '0;
        req_v        = '0;
        rsp_ready    = 1'b1;
        random_ready = 1'b0;
        hold_pending = 1'b0;
        held_addr    = '0;
        shadow_reset();
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        // Reset defaults give size 1 and clamp on every axis.
        lookup("reset default", 0, 0, 5, 7);
        lookup("reset default", 3, 7, -3, 100);
        lookup("reset default", 1, 2, 32767, -32768);

        order = '{2, 0, 3, 1};
        foreach (order[k]) begin
            s = order[k];
            dcr_write(tex_dcr_pkg::DCR_TEX_STAGE, (32'hFFFF_FFF0 * k) | s);
            dcr_write(tex_dcr_pkg::DCR_TEX_ADDR, 32'h0100_0040 * (s + 1));
            dcr_write(tex_dcr_pkg::DCR_TEX_FORMAT, s);
            dcr_write(tex_dcr_pkg::DCR_TEX_WRAP, {16'((s + 1) % 3), 16'(s % 3)});
            dcr_write(tex_dcr_pkg::DCR_TEX_LOGDIM, {16'(3 + s), 16'(5 - s)});
            for (j = 0; j <= tex_dcr_pkg::TEX_LOD_MAX; j++) begin
                write_mipoff(j, (s << 20) | (j << 12) | 32'h80);
            end
        end
        dcr_write(tex_dcr_pkg::DCR_TEX_STAGE, 0);
        dcr_write(tex_dcr_pkg::DCR_TEX_ADDR, 32'h0BAD_F000);
        bad_addrs = '{8'h00, 8'h06, 8'h07, 8'h10, 8'hFF};
        for (m = 0; m < 2; m++) begin
            for (s = 0; s < NUM_STAGES; s++) begin
                lookup("stage banking", s, 1, 13, -2);
                lookup("stage banking", s, 0, 100, 7);
            end
            if (m == 0) begin
                foreach (bad_addrs[k]) begin
                    dcr_write(bad_addrs[k], 32'hFFFF_FFFF);
                end
            end
        end

        // Stage 1 at 8 by 4 texels, each mode tried on both axes.
        coords = '{-1, -9, -17, 0, 3, 4, 5, 8, 16, 37};
        dcr_write(tex_dcr_pkg::DCR_TEX_STAGE, 1);
        dcr_write(tex_dcr_pkg::DCR_TEX_LOGDIM, {16'd2, 16'd3});
        for (m = 0; m < 4; m++) begin
            dcr_write(tex_dcr_pkg::DCR_TEX_WRAP, {16'((m + 1) % 4), 16'(m)});
            foreach (coords[k]) begin
                lookup("wrap u", 1, 0, coords[k], 1);
                lookup("wrap v", 1, 0, 2, coords[k]);
            end
        end

        dcr_write(tex_dcr_pkg::DCR_TEX_STAGE, 2);
        dcr_write(tex_dcr_pkg::DCR_TEX_LOGDIM, {16'd4, 16'd6});
        dcr_write(tex_dcr_pkg::DCR_TEX_WRAP, {16'd1, 16'd1});
        for (j = 0; j <= tex_dcr_pkg::TEX_LOD_MAX; j++) begin
            write_mipoff(j, ((j + 1) << 14) | j);
        end
        for (m = 0; m < 4; m++) begin
            dcr_write(tex_dcr_pkg::DCR_TEX_FORMAT, m);
            for (j = 0; j <= tex_dcr_pkg::TEX_LOD_MAX; j++) begin
                lookup("formats and lod", 2, j, 21, -3);
            end
        end

        drain();
        check_latency("latency", 1, 0, 3, 2);
        check_latency("latency", 3, 1, -4, 9);
        dcr_write(tex_dcr_pkg::DCR_TEX_STAGE, 0);
        lookup("write after accept", 0, 0, 4, 4);
        dcr_write(tex_dcr_pkg::DCR_TEX_ADDR, 32'hDEAD_0000);
        dcr_write(tex_dcr_pkg::DCR_TEX_FORMAT, 2);
        lookup("write visible", 0, 0, 4, 4);

        set_backpressure(1'b1);
        for (i = 0; i < NUM_RANDOM; i++) begin
            if (i % 64 == 63) begin
                rnd = $random(seed);
                dcr_write(tex_dcr_pkg::DCR_TEX_STAGE, rnd);
                dcr_write(tex_dcr_pkg::DCR_TEX_WRAP, rnd);
                dcr_write(tex_dcr_pkg::DCR_TEX_LOGDIM, (rnd & 32'h0007_0007) + 32'h0003_0003);
            end
            rnd = $random(seed);
            if (rnd[31:30] == 2'b00) begin
                @(posedge clk);
                #1;
            end
            u = $random(seed) % 3000;
            v = $random(seed) % 3000;
            lookup("random", int'(rnd % NUM_STAGES), int'(rnd[4:2]), u, v);
        end
        set_backpressure(1'b0);

        // With rsp_ready high again, the two lookups in flight leave within three cycles.
        repeat (4) @(posedge clk);
        #1;

        if (exp_q.size() != 0) begin
            report_failure("Lookups were left without a response at the end of the run.");
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+dv
verilog/tex_dcr_pkg.sv
verilog/tex_types_pkg.sv
verilog/tex_wrap.sv
verilog/tex_dcr.sv
verilog/tex_addr.sv
verilog/tex_unit.sv
dv/tex_unit_tb.sv

// ==== Bender.yml ====
package:
  name: tex_unit

sources:
  - files:
      - verilog/tex_dcr_pkg.sv
      - verilog/tex_types_pkg.sv
      - verilog/tex_wrap.sv
      - verilog/tex_dcr.sv
      - verilog/tex_addr.sv
      - verilog/tex_unit.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/tex_unit_tb.sv
